/* Makefile */
# Verilator build and run of the N-way tag memory testbench

SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/10ps -j 0
LINT     := --lint-only -Wall --timing --timescale 1ns/10ps
TOP      := tb_tag_mem_nway
FILELIST := all.f
BUILD    := obj_dir
LOG      := sim.log

SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* all.f */
design/cache_geom_pkg.sv
design/cache_bus_pkg.sv
design/tag_way_ram.sv
design/lru_nway.sv
design/tag_mem_nway.sv
tb/tb_line_model.sv
tb/tb_tag_mem_nway.sv

/* design/cache_bus_pkg.sv */
`default_nettype none

package cache_bus_pkg;

    // request from the cache controller, sampled every clock
    typedef struct packed {
        logic                   re;
        logic                   we;
        logic                   invalidate;
        logic                   direct_access;  // low address bits name the way
        cache_geom_pkg::addr_t  addr;
        cache_geom_pkg::line_t  wdata;
        cache_geom_pkg::strb_t  wstrb;
        cache_geom_pkg::flags_t wflags;
    } line_req_t;

    // lookup result for the previous request
    typedef struct packed {
        logic                   hit;
        cache_geom_pkg::addr_t  raddr;          // line aligned
        cache_geom_pkg::line_t  rdata;
        cache_geom_pkg::flags_t rflags;
    } line_resp_t;

    // per-way port, a way writes when any strobe is set
    typedef struct packed {
        cache_geom_pkg::addr_t  addr;
        cache_geom_pkg::strb_t  wstrb;
        cache_geom_pkg::line_t  wdata;
        cache_geom_pkg::flags_t wflags;
    } way_in_t;

    typedef struct packed {
        cache_geom_pkg::addr_t  raddr;
        cache_geom_pkg::line_t  rdata;
        cache_geom_pkg::flags_t rflags;
        logic                   hit;
    } way_out_t;

endpackage : cache_bus_pkg

`default_nettype wire

/* design/cache_geom_pkg.sv */
`default_nettype none

package cache_geom_pkg;

    // system address and line geometry
    localparam int ABUS       = 32;
    localparam int LNBITS     = 4;               // log2 of bytes per line
    localparam int LINE_BYTES = 2 ** LNBITS;
    localparam int LINE_W     = 8 * LINE_BYTES;

    // flags stored next to each tag
    localparam int FLBITS   = 4;
    localparam int FL_VALID = 0;
    localparam int FL_DIRTY = 1;                 // set by the controller on stores

    typedef logic [ABUS-1:0]       addr_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [LINE_BYTES-1:0] strb_t;       // one bit per line byte
    typedef logic [FLBITS-1:0]     flags_t;

endpackage : cache_geom_pkg

`default_nettype wire

/* design/lru_nway.sv */
`default_nettype none

module lru_nway #(
    parameter int WAYBITS = 2,
    parameter int IBITS   = 4
) (
    input  logic               i_clk,
    input  logic               i_nrst,
    input  logic               i_init,
    input  logic               i_up,
    input  logic               i_down,
    input  logic [IBITS-1:0]   i_raddr,
    input  logic [IBITS-1:0]   i_waddr,
    input  logic [WAYBITS-1:0] i_way,
    output logic [WAYBITS-1:0] o_lru
);

    localparam int NWAYS = 2 ** WAYBITS;
    localparam int DEPTH = 2 ** IBITS;

    // entry 0 is the least recent way, entry NWAYS-1 the most recent
    typedef logic [NWAYS-1:0][WAYBITS-1:0] order_t;

    order_t lru_mem [DEPTH];
    order_t cur_order;
    order_t new_order;
    logic   upd;

    function automatic order_t identity_order();
        order_t ord;
        for (int k = 0; k < NWAYS; k++) begin
            ord[k] = WAYBITS'(k);
        end
        return ord;
    endfunction

    assign cur_order = lru_mem[i_waddr];
    assign upd       = i_init | i_up | i_down;

    always_comb begin
        int pos;
        pos = 0;
        for (int k = 0; k < NWAYS; k++) begin
            if (cur_order[k] == i_way) pos = k;  // where i_way sits now
        end
        new_order = cur_order;
        if (i_init) begin
            new_order = identity_order();
        end else if (i_up) begin
            // close the gap and append at the recent end
            for (int k = 0; k < NWAYS - 1; k++) begin
                if (k >= pos) new_order[k] = cur_order[k+1];
            end
            new_order[NWAYS-1] = i_way;
        end else if (i_down) begin
            // shift older entries up by one, put i_way first
            for (int k = 1; k < NWAYS; k++) begin
                if (k <= pos) new_order[k] = cur_order[k-1];
            end
            new_order[0] = i_way;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int d = 0; d < DEPTH; d++) begin
                lru_mem[d] <= identity_order();
            end
        end else if (upd) begin
            lru_mem[i_waddr] <= new_order;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_lru <= '0;
        end else if (upd && (i_raddr == i_waddr)) begin
            o_lru <= new_order[0];               // bypass the order being written
        end else begin
            o_lru <= lru_mem[i_raddr][0];
        end
    end

endmodule : lru_nway

`default_nettype wire

/* design/tag_mem_nway.sv */
`default_nettype none

module tag_mem_nway #(
    parameter int WAYBITS = 2,                   // log2 of way count
    parameter int IBITS   = 4                    // index width
) (
    input  logic                      i_clk,
    input  logic                      i_nrst,
    input  cache_bus_pkg::line_req_t  i_req,
    output cache_bus_pkg::line_resp_t o_resp
);

    localparam int NWAYS  = 2 ** WAYBITS;
    localparam int LNBITS = cache_geom_pkg::LNBITS;

    cache_bus_pkg::way_in_t  way_i [NWAYS];
    cache_bus_pkg::way_out_t way_o [NWAYS];

    // previous request
    logic                  r_re;
    logic                  r_inv;
    logic                  r_direct;
    cache_geom_pkg::addr_t r_addr;

    logic [WAYBITS-1:0]     sel_way;
    logic [WAYBITS-1:0]     lru_way;
    logic                   sel_hit;
    logic                   way_we;
    cache_geom_pkg::strb_t  wstrb;
    cache_geom_pkg::flags_t wflags;

    logic               lru_up;
    logic               lru_down;
    logic               lru_init;
    logic [IBITS-1:0]   lru_raddr;
    logic [IBITS-1:0]   lru_waddr;

    for (genvar i = 0; i < NWAYS; i++) begin : g_way
        tag_way_ram #(
            .IBITS (IBITS)
        ) u_way (
            .i_clk  (i_clk),
            .i_nrst (i_nrst),
            .i_way  (way_i[i]),
            .o_way  (way_o[i])
        );
    end

    lru_nway #(
        .WAYBITS (WAYBITS),
        .IBITS   (IBITS)
    ) u_lru (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_init  (lru_init),
        .i_up    (lru_up),
        .i_down  (lru_down),
        .i_raddr (lru_raddr),
        .i_waddr (lru_waddr),
        .i_way   (sel_way),
        .o_lru   (lru_way)
    );

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_re     <= 1'b0;
            r_inv    <= 1'b0;
            r_direct <= 1'b0;
        end else begin
            r_re     <= i_req.re;
            r_inv    <= i_req.invalidate;
            r_direct <= i_req.direct_access;
        end
    end

    always_ff @(posedge i_clk) begin
        r_addr <= i_req.addr;
    end

    // way select: direct index, else hitting way, else LRU victim
    always_comb begin
        sel_way = lru_way;
        if (r_direct) begin
            sel_way = r_addr[WAYBITS-1:0];
        end else begin
            for (int i = 0; i < NWAYS; i++) begin
                if (way_o[i].hit) sel_way = WAYBITS'(i);
            end
        end
    end

    assign sel_hit = way_o[sel_way].hit;

    always_comb begin
        o_resp.hit    = sel_hit;
        o_resp.raddr  = way_o[sel_way].raddr;
        o_resp.rdata  = way_o[sel_way].rdata;
        o_resp.rflags = way_o[sel_way].rflags;
    end

    // invalidation rewrites the whole line with cleared flags
    always_comb begin
        if (r_inv) begin
            wstrb  = '1;
            wflags = '0;
        end else begin
            wstrb  = i_req.wstrb;
            wflags = i_req.wflags;
        end
    end

    // a write only lands on a line looked up the cycle before
    assign way_we = i_req.we || (r_inv && sel_hit);

    always_comb begin
        for (int i = 0; i < NWAYS; i++) begin
            way_i[i].addr   = i_req.addr;
            way_i[i].wdata  = i_req.wdata;
            way_i[i].wflags = wflags;
            way_i[i].wstrb  = '0;
            if (way_we && (sel_way == WAYBITS'(i))) begin
                way_i[i].wstrb = wstrb;          // only the selected way sees strobes
            end
        end
    end

    // LRU update lands on the same edge as the way write
    assign lru_init  = r_direct;
    assign lru_up    = i_req.we || (sel_hit && r_re);
    assign lru_down  = sel_hit && r_inv;         // invalidated line is the next victim
    assign lru_raddr = i_req.addr[IBITS+LNBITS-1:LNBITS];
    assign lru_waddr = r_addr[IBITS+LNBITS-1:LNBITS];

endmodule : tag_mem_nway

`default_nettype wire

/* design/tag_way_ram.sv */
`default_nettype none

module tag_way_ram #(
    parameter int IBITS = 4                      // index width, 2**IBITS sets
) (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  cache_bus_pkg::way_in_t  i_way,
    output cache_bus_pkg::way_out_t o_way
);

    localparam int DEPTH  = 2 ** IBITS;
    localparam int LNBITS = cache_geom_pkg::LNBITS;
    localparam int ABUS   = cache_geom_pkg::ABUS;

    logic [IBITS-1:0]       idx;
    logic                   wr_en;
    cache_geom_pkg::addr_t  line_addr;

    // storage arrays, one entry per set
    cache_geom_pkg::addr_t  tag_mem  [DEPTH];
    cache_geom_pkg::flags_t flag_mem [DEPTH];
    cache_geom_pkg::line_t  data_mem [DEPTH];

    // registered read port
    cache_geom_pkg::addr_t  r_req_addr;
    cache_geom_pkg::addr_t  r_tag;
    cache_geom_pkg::flags_t r_flags;
    cache_geom_pkg::line_t  r_data;

    assign idx       = i_way.addr[IBITS+LNBITS-1:LNBITS];
    assign line_addr = {i_way.addr[ABUS-1:LNBITS], {LNBITS{1'b0}}};
    assign wr_en     = |i_way.wstrb;

    // flags are the only array cleared on reset, so every line comes up invalid
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < DEPTH; i++) begin
                flag_mem[i] <= '0;
            end
        end else if (wr_en) begin
            flag_mem[idx] <= i_way.wflags;
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            tag_mem[idx] <= line_addr;           // whole line address is the tag
        end
        for (int b = 0; b < cache_geom_pkg::LINE_BYTES; b++) begin
            if (i_way.wstrb[b]) begin
                data_mem[idx][8*b +: 8] <= i_way.wdata[8*b +: 8];
            end
        end
    end

    // read returns the contents before a write on the same edge
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_flags <= '0;
        end else begin
            r_flags <= flag_mem[idx];
        end
    end

    always_ff @(posedge i_clk) begin
        r_tag      <= tag_mem[idx];
        r_data     <= data_mem[idx];
        r_req_addr <= line_addr;                 // compared one cycle later
    end

    always_comb begin
        o_way.raddr  = r_tag;
        o_way.rdata  = r_data;
        o_way.rflags = r_flags;
        o_way.hit    = r_flags[cache_geom_pkg::FL_VALID] && (r_tag == r_req_addr);
    end

endmodule : tag_way_ram

`default_nettype wire

/* tb/tb_line_model.sv */
`default_nettype none

module tb_line_model #(
    parameter int WAYBITS = 2,
    parameter int IBITS   = 4
) (
    input  logic                      i_clk,
    input  logic                      i_nrst,
    input  cache_bus_pkg::line_req_t  i_req,
    output cache_bus_pkg::line_resp_t o_exp,
    output logic                      o_chk,     // response belongs to a read
    output logic                      o_known    // raddr and rdata are fully defined
);

    timeunit 1ns;
    timeprecision 10ps;

    localparam int NWAYS  = 2 ** WAYBITS;
    localparam int NSETS  = 2 ** IBITS;
    localparam int LNBITS = cache_geom_pkg::LNBITS;

    cache_geom_pkg::addr_t  tags  [NWAYS][NSETS];
    cache_geom_pkg::flags_t flags [NWAYS][NSETS];
    cache_geom_pkg::line_t  data  [NWAYS][NSETS];
    logic                   full  [NWAYS][NSETS];    // every byte written at least once
    int                     order [NSETS][NWAYS];    // least recent first

    cache_bus_pkg::line_req_t prev;                  // request looked up on the last edge
    int                       prev_way;
    logic                     prev_hit;

    function automatic cache_geom_pkg::addr_t line_of(input cache_geom_pkg::addr_t a);
        return a & ~cache_geom_pkg::addr_t'(cache_geom_pkg::LINE_BYTES - 1);
    endfunction

    function automatic int set_of(input cache_geom_pkg::addr_t a);
        return int'(a[IBITS+LNBITS-1:LNBITS]);
    endfunction

    // move a way to the most recent end
    task automatic promote(input int s, input int w);
        int pos;
        pos = 0;
        for (int k = 0; k < NWAYS; k++) begin
            if (order[s][k] == w) pos = k;
        end
        for (int k = pos; k < NWAYS - 1; k++) begin
            order[s][k] = order[s][k+1];
        end
        order[s][NWAYS-1] = w;
    endtask

    // move a way to the least recent end
    task automatic demote(input int s, input int w);
        int pos;
        pos = 0;
        for (int k = 0; k < NWAYS; k++) begin
            if (order[s][k] == w) pos = k;
        end
        for (int k = pos; k > 0; k--) begin
            order[s][k] = order[s][k-1];
        end
        order[s][0] = w;
    endtask

    always @(posedge i_clk or negedge i_nrst) begin
        cache_geom_pkg::addr_t  s_tag  [NWAYS];
        cache_geom_pkg::flags_t s_flag [NWAYS];
        cache_geom_pkg::line_t  s_data [NWAYS];
        logic                   s_full [NWAYS];
        cache_geom_pkg::strb_t  strb;
        cache_geom_pkg::flags_t fl;
        logic                   wr;
        logic                   hit;
        int                     rs;
        int                     ws;
        int                     way;
        if (!i_nrst) begin
            for (int w = 0; w < NWAYS; w++) begin
                for (int s = 0; s < NSETS; s++) begin
                    flags[w][s] = '0;
                    full[w][s]  = 1'b0;
                    order[s][w] = w;
                end
            end
            prev     = '0;
            prev_way = 0;
            prev_hit = 1'b0;
            o_exp   <= '0;
            o_chk   <= 1'b0;
            o_known <= 1'b0;
        end else begin
            // the new request sees the set as it was before this edge's write
            rs = set_of(i_req.addr);
            for (int w = 0; w < NWAYS; w++) begin
                s_tag[w]  = tags[w][rs];
                s_flag[w] = flags[w][rs];
                s_data[w] = data[w][rs];
                s_full[w] = full[w][rs];
            end

            wr   = 1'b0;
            strb = '0;
            fl   = '0;
            if (prev.invalidate && prev_hit) begin
                wr   = 1'b1;
                strb = '1;                           // dead line, flags cleared
            end else if (i_req.we) begin
                wr   = |i_req.wstrb;
                strb = i_req.wstrb;
                fl   = i_req.wflags;
            end
            ws = set_of(i_req.addr);
            if (wr) begin
                tags[prev_way][ws]  = line_of(i_req.addr);
                flags[prev_way][ws] = fl;
                for (int b = 0; b < cache_geom_pkg::LINE_BYTES; b++) begin
                    if (strb[b]) data[prev_way][ws][8*b +: 8] = i_req.wdata[8*b +: 8];
                end
                if (strb == '1) full[prev_way][ws] = 1'b1;
            end

            // recency of the previous request's set
            ws = set_of(prev.addr);
            if (prev.direct_access) begin
                for (int k = 0; k < NWAYS; k++) begin
                    order[ws][k] = k;
                end
            end else if (i_req.we || (prev_hit && prev.re)) begin
                promote(ws, prev_way);
            end else if (prev_hit && prev.invalidate) begin
                demote(ws, prev_way);
            end

            way = order[rs][0];                      // victim unless something hits
            if (i_req.direct_access) begin
                way = int'(i_req.addr[WAYBITS-1:0]);
            end else begin
                for (int w = 0; w < NWAYS; w++) begin
                    if (s_flag[w][cache_geom_pkg::FL_VALID] &&
                        s_tag[w] == line_of(i_req.addr)) way = w;
                end
            end
            hit = s_flag[way][cache_geom_pkg::FL_VALID] && (s_tag[way] == line_of(i_req.addr));

            o_exp.hit    <= hit;
            o_exp.raddr  <= s_tag[way];
            o_exp.rdata  <= s_data[way];
            o_exp.rflags <= s_flag[way];
            o_chk        <= i_req.re;
            o_known      <= s_full[way];
            prev     = i_req;
            prev_way = way;
            prev_hit = hit;
        end
    end

endmodule : tb_line_model

`default_nettype wire

/* tb/tb_tag_mem_nway.sv */
`default_nettype none

module tb_tag_mem_nway;

    timeunit 1ns;
    timeprecision 10ps;

    localparam int WAYBITS     = 2;
    localparam int IBITS       = 4;
    localparam int NWAYS       = 2 ** WAYBITS;
    localparam int LNBITS      = cache_geom_pkg::LNBITS;
    localparam int TAGW        = cache_geom_pkg::ABUS - IBITS - LNBITS;
    localparam int MAX_CYCLES  = 6000;
    localparam int LOOKUP_WAIT = 4;                  // cycles allowed for a lookup result

    localparam cache_geom_pkg::flags_t VALID_FL =
        cache_geom_pkg::flags_t'(1 << cache_geom_pkg::FL_VALID);

    logic                      clk;
    logic                      nrst;
    cache_bus_pkg::line_req_t  req;
    cache_bus_pkg::line_resp_t resp;
    cache_bus_pkg::line_resp_t exp_resp;
    logic                      exp_chk;
    logic                      exp_known;
    int                        mismatches = 0;
    int                        timeouts = 0;

    tag_mem_nway #(
        .WAYBITS (WAYBITS),
        .IBITS   (IBITS)
    ) uut (
        .i_clk  (clk),
        .i_nrst (nrst),
        .i_req  (req),
        .o_resp (resp)
    );

    tb_line_model #(
        .WAYBITS (WAYBITS),
        .IBITS   (IBITS)
    ) u_model (
        .i_clk   (clk),
        .i_nrst  (nrst),
        .i_req   (req),
        .o_exp   (exp_resp),
        .o_chk   (exp_chk),
        .o_known (exp_known)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string what);
        mismatches++;
        $display("Mismatch at %0t: %s", $time, what);
    endtask

    // outputs are checked mid cycle, well away from the driving edge
    hit_follows_model: assert property (@(negedge clk) disable iff (!nrst)
        (!exp_chk || resp.hit === exp_resp.hit))
        else report_mismatch($sformatf("hit %0b expected %0b", resp.hit, exp_resp.hit));

    always @(negedge clk) begin
        if (nrst && exp_chk) begin
            flags_ok: assert (resp.rflags === exp_resp.rflags)
                else report_mismatch($sformatf("rflags %h expected %h",
                                               resp.rflags, exp_resp.rflags));
            if (exp_known) begin
                raddr_ok: assert (resp.raddr === exp_resp.raddr)
                    else report_mismatch($sformatf("raddr %h expected %h",
                                                   resp.raddr, exp_resp.raddr));
                rdata_ok: assert (resp.rdata === exp_resp.rdata)
                    else report_mismatch($sformatf("rdata %h expected %h",
                                                   resp.rdata, exp_resp.rdata));
            end
        end
    end

    function automatic cache_geom_pkg::addr_t make_addr(input int tag, input int set,
                                                        input int off);
        return {TAGW'(tag), IBITS'(set), LNBITS'(off)};
    endfunction

    function automatic cache_geom_pkg::line_t rand_line();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    function automatic cache_bus_pkg::line_req_t idle_at(input cache_geom_pkg::addr_t a);
        cache_bus_pkg::line_req_t r;
        r      = '0;
        r.addr = a;                                  // address held between requests
        return r;
    endfunction

    task automatic drive_req(input cache_bus_pkg::line_req_t r);
        @(posedge clk);
        req <= r;
    endtask

    task automatic wait_lookup(output cache_bus_pkg::line_resp_t r);
        int n;
        n = 0;
        @(negedge clk);
        while (!exp_chk && n < LOOKUP_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (!exp_chk) begin
            timeouts++;
            $display("no lookup result %0d cycles after a read at %0t", LOOKUP_WAIT, $time);
        end
        r = resp;
    endtask

    // read, then a write or an idle cycle on the same address
    task automatic access(input cache_geom_pkg::addr_t a, input logic direct, input logic wr,
                          input cache_geom_pkg::line_t d, input cache_geom_pkg::strb_t s,
                          input cache_geom_pkg::flags_t f,
                          output cache_bus_pkg::line_resp_t r);
        cache_bus_pkg::line_req_t q;
        q               = idle_at(a);
        q.re            = 1'b1;
        q.direct_access = direct;
        drive_req(q);
        q        = idle_at(a);
        q.we     = wr;
        q.wdata  = d;
        q.wstrb  = s;
        q.wflags = f;
        drive_req(q);
        wait_lookup(r);
        drive_req(idle_at(a));
    endtask

    task automatic read_line(input cache_geom_pkg::addr_t a,
                             output cache_bus_pkg::line_resp_t r);
        access(a, 1'b0, 1'b0, '0, '0, '0, r);
    endtask

    task automatic invalidate_line(input cache_geom_pkg::addr_t a);
        cache_bus_pkg::line_req_t q;
        q            = idle_at(a);
        q.invalidate = 1'b1;
        drive_req(q);
        q       = idle_at(a);
        q.wdata = rand_line();                       // lands on the dead line
        drive_req(q);
        drive_req(idle_at(a));
    endtask

    initial begin
        cache_bus_pkg::line_resp_t r;
        cache_geom_pkg::addr_t     a;
        cache_geom_pkg::addr_t     lines [6];
        cache_geom_pkg::line_t     d;
        cache_geom_pkg::line_t     d2;
        cache_geom_pkg::strb_t     s;
        void'($urandom(32'ha49744cb));
        nrst = 1'b0;
        req  = '0;
        repeat (3) @(posedge clk);
        nrst <= 1'b1;

        for (int i = 0; i < 8; i++) begin
            read_line(make_addr(int'($urandom_range(0, 63)), int'($urandom_range(0, 15)), 0), r);
            empty_after_reset: assert (r.hit === 1'b0)
                else report_mismatch("hit before any line was written");
        end

        // fill on a miss, then merge a partial write into the hit line
        for (int i = 0; i < 6; i++) begin
            a = make_addr(i + 1, i, int'($urandom_range(0, 15)));
            d = rand_line();
            access(a, 1'b0, 1'b1, d, '1, VALID_FL, r);
            read_line(a, r);
            fill_returned: assert (r.hit && r.raddr == {a[31:LNBITS], 4'h0} && r.rdata == d)
                else report_mismatch($sformatf("line %h not returned after fill", a));
            d2 = rand_line();
            s  = cache_geom_pkg::strb_t'($urandom_range(1, 65534));
            access(a, 1'b0, 1'b1, d2, s, VALID_FL, r);
            read_line(a, r);
            for (int b = 0; b < cache_geom_pkg::LINE_BYTES; b++) begin
                if (s[b]) d[8*b +: 8] = d2[8*b +: 8];
            end
            bytes_merged: assert (r.rdata == d)
                else report_mismatch($sformatf("partial write to %h merged wrongly", a));
        end

        for (int i = 0; i < 5; i++) begin
            lines[i] = make_addr(20 + i, 9, 0);
            access(lines[i], 1'b0, 1'b1, rand_line(), '1, VALID_FL, r);
        end
        for (int i = 0; i < 5; i++) begin
            read_line(lines[i], r);
            oldest_evicted: assert (r.hit == (i != 0))
                else report_mismatch($sformatf("line %0d of the set hit %0b", i, r.hit));
        end

        // line 1 is least recent now, a hit on it pushes the next victim to line 2
        lines[5] = make_addr(25, 9, 0);
        read_line(lines[1], r);
        access(lines[5], 1'b0, 1'b1, rand_line(), '1, VALID_FL, r);
        read_line(lines[1], r);
        kept_after_hit: assert (r.hit) else report_mismatch("recently read line was evicted");
        read_line(lines[2], r);
        victim_gone: assert (!r.hit) else report_mismatch("least recent line still hits");

        invalidate_line(lines[3]);
        read_line(lines[3], r);
        dead_line: assert (!r.hit) else report_mismatch("invalidated line still hits");
        read_line(lines[1], r);
        others_kept: assert (r.hit) else report_mismatch("invalidate hit another way");
        read_line(lines[4], r);
        others_kept2: assert (r.hit) else report_mismatch("invalidate hit another way");

        for (int w = 0; w < NWAYS; w++) begin
            access(make_addr(int'($urandom_range(100, 200)), 9, w), 1'b1, 1'b0, '0, '0, '0, r);
        end

        // identity order again, so way 0 with line 4 is the next victim
        access(make_addr(30, 9, 0), 1'b0, 1'b1, rand_line(), '1, VALID_FL, r);
        read_line(lines[4], r);
        order_reset: assert (!r.hit)
            else report_mismatch("direct access left the LRU order in place");

        for (int n = 0; n < 300; n++) begin
            a = make_addr(int'($urandom_range(40, 45)), int'($urandom_range(0, 3)),
                          int'($urandom_range(0, 15)));
            case ($urandom_range(0, 3))
                0: read_line(a, r);
                1: invalidate_line(a);
                default: access(a, 1'b0, 1'b1, rand_line(),
                                cache_geom_pkg::strb_t'($urandom_range(1, 65535)),
                                cache_geom_pkg::flags_t'($urandom_range(0, 15)), r);
            endcase
        end

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        for (int cyc = 0; cyc < MAX_CYCLES; cyc++) begin
            @(posedge clk);
        end
        $display("simulation did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule : tb_tag_mem_nway

`default_nettype wire
